// ==== hdl/l1d_defs.svh ====
`ifndef L1D_DEFS_SVH
`define L1D_DEFS_SVH

// ********************************************************************
// datapath widths
// ********************************************************************
`define L1D_XLEN        64
`define L1D_ADDR_W      4 // 16 bank words.
`define L1D_ROB_TAG_W   4
`define L1D_PREG_TAG_W  6
`define L1D_PTW_ID_W    1

// ********************************************************************
// buffer depths and store opcodes
// ********************************************************************
`define L1D_STB_DEPTH   8
`define L1D_QUEUE_DEPTH 2

`define L1D_ST_OP_W     2
`define L1D_ST_OP_SB    2'd0 // low byte.
`define L1D_ST_OP_SH    2'd1
`define L1D_ST_OP_SW    2'd2
`define L1D_ST_OP_SD    2'd3 // full word.

`endif

// ==== hdl/l1d_req_pkg.sv ====
`include "l1d_defs.svh"

package l1d_req_pkg;

	typedef struct packed {
		logic [`L1D_ROB_TAG_W-1:0]  rob_tag;
		logic [`L1D_PREG_TAG_W-1:0] prd;
		logic [`L1D_ADDR_W-1:0]     addr;
	} ld_req_t;

	typedef struct packed {
		logic [`L1D_ROB_TAG_W-1:0] rob_tag;
		logic [`L1D_ST_OP_W-1:0]   op;
		logic [`L1D_ADDR_W-1:0]    addr;
		logic [`L1D_XLEN-1:0]      data;
	} st_req_t;

	typedef struct packed {
		logic [`L1D_PTW_ID_W-1:0] id;
		logic [`L1D_ADDR_W-1:0]   addr;
	} ptw_req_t;

	typedef struct packed {
		logic                      wr; // drain write, else a read.
		logic [`L1D_ADDR_W-1:0]    addr;
		logic [`L1D_XLEN-1:0]      data;
		logic [`L1D_XLEN/8-1:0]    mask;
	} bank_req_t;

	typedef enum logic [1:0] {
		OWNER_LD,
		OWNER_PTW,
		OWNER_ST
	} bank_owner_e;

endpackage

// ==== hdl/l1d_resp_pkg.sv ====
`include "l1d_defs.svh"

package l1d_resp_pkg;

	typedef struct packed {
		logic [`L1D_ROB_TAG_W-1:0] rob_tag;
	} rob_wb_t;

	typedef struct packed {
		logic [`L1D_PREG_TAG_W-1:0] prd;
		logic [`L1D_XLEN-1:0]       data;
	} prf_wb_t;

	// walk result, pte is the raw bank word.
	typedef struct packed {
		logic [`L1D_PTW_ID_W-1:0] id;
		logic [`L1D_XLEN-1:0]     pte;
	} ptw_resp_t;

endpackage

// ==== hdl/l1d_req_queue.sv ====
`timescale 1ns/1ps
`include "l1d_defs.svh"

module l1d_req_queue #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n_i,
	input  logic     push_vld_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output logic     push_rdy_o,
	output logic     head_vld_o,
	output payload_t head_data_o,
	output logic     empty_o
);
	localparam int DEPTH = `L1D_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t         mem_q [DEPTH];
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W:0]   count_q;
	logic             full;
	logic             push;
	logic             pop;

	assign full        = (count_q == (PTR_W+1)'(DEPTH));
	assign empty_o     = (count_q == '0);
	assign push_rdy_o  = ~full;
	assign head_vld_o  = ~empty_o;
	assign head_data_o = mem_q[rd_ptr_q];
	assign push        = push_vld_i & push_rdy_o;
	assign pop         = pop_i & head_vld_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_q[wr_ptr_q] <= push_data_i;
		end
	end

	// the arbiter only pops a head it was shown.
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
		pop_i |-> !empty_o);
	// a push never lands on the live head entry.
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		push |-> empty_o || (wr_ptr_q != rd_ptr_q));

endmodule

// ==== hdl/l1d_store_buffer.sv ====
`timescale 1ns/1ps
`include "l1d_defs.svh"

module l1d_store_buffer (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   st_vld_i,
	input  l1d_req_pkg::st_req_t   st_req_i,
	input  logic                   drain_gnt_i,
	input  logic                   byp_vld_i,
	input  logic [`L1D_ADDR_W-1:0] byp_addr_i,
	input  logic [`L1D_XLEN-1:0]   byp_data_i,
	output logic                   st_rdy_o,
	output logic                   rob_wb_vld_o,
	output l1d_resp_pkg::rob_wb_t  rob_wb_o,
	output logic                   drain_vld_o,
	output l1d_req_pkg::bank_req_t drain_req_o,
	output logic [`L1D_XLEN-1:0]   byp_data_o,
	output logic                   empty_o
);
	localparam int DEPTH  = `L1D_STB_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int NBYTES = `L1D_XLEN / 8;

	logic [`L1D_ADDR_W-1:0] addr_q [DEPTH];
	logic [`L1D_XLEN-1:0]   data_q [DEPTH];
	logic [NBYTES-1:0]      mask_q [DEPTH];
	logic [PTR_W-1:0]       head_q;
	logic [PTR_W-1:0]       tail_q;
	logic [PTR_W:0]         count_q;
	logic [NBYTES-1:0]      st_mask;
	logic                   push;
	logic                   pop;

	// ********************************************************************
	// accept, report to the rob, drain oldest first
	// ********************************************************************
	always_comb begin
		case (st_req_i.op)
			`L1D_ST_OP_SB: st_mask = NBYTES'(1);
			`L1D_ST_OP_SH: st_mask = NBYTES'(3);
			`L1D_ST_OP_SW: st_mask = NBYTES'(15);
			default:       st_mask = '1;
		endcase
	end

	assign empty_o  = (count_q == '0);
	assign st_rdy_o = (count_q != (PTR_W+1)'(DEPTH));
	assign push     = st_vld_i & st_rdy_o;
	assign pop      = drain_gnt_i & ~empty_o;

	assign rob_wb_vld_o     = push; // same cycle as the handshake.
	assign rob_wb_o.rob_tag = st_req_i.rob_tag;

	assign drain_vld_o      = ~empty_o;
	assign drain_req_o.wr   = 1'b1;
	assign drain_req_o.addr = addr_q[head_q];
	assign drain_req_o.data = data_q[head_q];
	assign drain_req_o.mask = mask_q[head_q];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				tail_q <= tail_q + 1'b1;
			end
			if (pop) begin
				head_q <= head_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			addr_q[tail_q] <= st_req_i.addr;
			data_q[tail_q] <= st_req_i.data;
			mask_q[tail_q] <= st_mask;
		end
	end

	// ********************************************************************
	// load bypass
	// ********************************************************************
	// walk from oldest to youngest so the last matching byte wins.
	always_comb begin
		logic [PTR_W-1:0] idx;
		byp_data_o = byp_data_i;
		for (int i = 0; i < DEPTH; i++) begin
			idx = head_q + PTR_W'(i);
			if (byp_vld_i && (i < count_q) && (addr_q[idx] == byp_addr_i)) begin
				for (int b = 0; b < NBYTES; b++) begin
					if (mask_q[idx][b]) begin
						byp_data_o[b*8 +: 8] = data_q[idx][b*8 +: 8];
					end
				end
			end
		end
	end

	a_no_gnt_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
		drain_gnt_i |-> !empty_o);

endmodule

// ==== hdl/l1d_bank_arbiter.sv ====
`timescale 1ns/1ps

module l1d_bank_arbiter (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     ld_vld_i,
	input  l1d_req_pkg::ld_req_t     ld_req_i,
	input  logic                     ptw_vld_i,
	input  l1d_req_pkg::ptw_req_t    ptw_req_i,
	input  logic                     st_vld_i,
	input  l1d_req_pkg::bank_req_t   st_req_i,
	input  logic                     stb_full_i,
	input  logic                     ptw_hold_i,
	output logic                     ld_gnt_o,
	output logic                     ptw_gnt_o,
	output logic                     st_gnt_o,
	output logic                     bank_vld_o,
	output l1d_req_pkg::bank_req_t   bank_req_o,
	output l1d_req_pkg::bank_owner_e rd_owner_o,
	output l1d_req_pkg::ld_req_t     rd_ld_o,
	output l1d_req_pkg::ptw_req_t    rd_ptw_o,
	output logic                     rd_busy_o
);
	always_comb begin
		ld_gnt_o  = 1'b0;
		ptw_gnt_o = 1'b0;
		st_gnt_o  = 1'b0;
		if (st_vld_i && stb_full_i) begin
			st_gnt_o = 1'b1; // full buffer would stall new stores.
		end else if (ptw_vld_i && !ptw_hold_i) begin
			ptw_gnt_o = 1'b1;
		end else if (ld_vld_i) begin
			ld_gnt_o = 1'b1;
		end else if (st_vld_i) begin
			st_gnt_o = 1'b1;
		end
	end

	always_comb begin
		bank_req_o = st_req_i;
		if (ptw_gnt_o) begin
			bank_req_o.wr   = 1'b0;
			bank_req_o.addr = ptw_req_i.addr;
		end else if (ld_gnt_o) begin
			bank_req_o.wr   = 1'b0;
			bank_req_o.addr = ld_req_i.addr;
		end
	end

	assign bank_vld_o = ld_gnt_o | ptw_gnt_o | st_gnt_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_busy_o  <= 1'b0;
			rd_owner_o <= l1d_req_pkg::OWNER_ST;
		end else begin
			rd_busy_o <= ld_gnt_o | ptw_gnt_o;
			if (ptw_gnt_o) begin
				rd_owner_o <= l1d_req_pkg::OWNER_PTW;
			end else if (ld_gnt_o) begin
				rd_owner_o <= l1d_req_pkg::OWNER_LD;
			end else if (st_gnt_o) begin
				rd_owner_o <= l1d_req_pkg::OWNER_ST;
			end
		end
	end

	// tags ride along with the read for one cycle.
	always_ff @(posedge clk) begin
		rd_ld_o  <= ld_req_i;
		rd_ptw_o <= ptw_req_i;
	end

	// a bank read belongs to exactly one read grant.
	a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
		bank_vld_o && !bank_req_o.wr |-> $onehot({ld_gnt_o, ptw_gnt_o}));

endmodule

// ==== hdl/l1d_data_bank.sv ====
`timescale 1ns/1ps
`include "l1d_defs.svh"

module l1d_data_bank (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     req_vld_i,
	input  l1d_req_pkg::bank_req_t   req_i,
	input  l1d_req_pkg::bank_owner_e rd_owner_i,
	input  l1d_req_pkg::ld_req_t     rd_ld_i,
	input  l1d_req_pkg::ptw_req_t    rd_ptw_i,
	input  logic                     ptw_resp_rdy_i,
	output logic [`L1D_XLEN-1:0]     rd_data_o,
	output logic                     ld_rd_vld_o,
	output l1d_resp_pkg::prf_wb_t    ld_wb_o,
	output l1d_resp_pkg::rob_wb_t    ld_rob_o,
	output logic                     ptw_resp_vld_o,
	output l1d_resp_pkg::ptw_resp_t  ptw_resp_o,
	output logic                     ptw_hold_o
);
	localparam int WORDS  = 1 << `L1D_ADDR_W;
	localparam int NBYTES = `L1D_XLEN / 8;

	logic [`L1D_XLEN-1:0]    mem_q [WORDS];
	logic [`L1D_XLEN-1:0]    rd_q;
	logic                    rd_vld_q;
	logic                    ptw_rd;
	logic                    hold_vld_q;
	l1d_resp_pkg::ptw_resp_t hold_q;

	always_ff @(posedge clk) begin
		if (req_vld_i) begin
			if (req_i.wr) begin
				for (int b = 0; b < NBYTES; b++) begin
					if (req_i.mask[b]) begin
						mem_q[req_i.addr][b*8 +: 8] <= req_i.data[b*8 +: 8];
					end
				end
			end else begin
				rd_q <= mem_q[req_i.addr];
			end
		end
	end

	assign rd_data_o   = rd_q;
	assign ptw_rd      = rd_vld_q & (rd_owner_i == l1d_req_pkg::OWNER_PTW);
	assign ld_rd_vld_o = rd_vld_q & (rd_owner_i == l1d_req_pkg::OWNER_LD);

	assign ld_wb_o.prd      = rd_ld_i.prd;
	assign ld_wb_o.data     = rd_q;
	assign ld_rob_o.rob_tag = rd_ld_i.rob_tag;

	// ********************************************************************
	// walk response, held until the walker takes it
	// ********************************************************************
	assign ptw_resp_vld_o = hold_vld_q | ptw_rd;
	assign ptw_resp_o     = hold_vld_q ? hold_q :
		l1d_resp_pkg::ptw_resp_t'{id: rd_ptw_i.id, pte: rd_q};
	assign ptw_hold_o     = ptw_resp_vld_o & ~ptw_resp_rdy_i; // stops further walk grants.

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_vld_q   <= 1'b0;
			hold_vld_q <= 1'b0;
		end else begin
			rd_vld_q <= req_vld_i & ~req_i.wr;
			if (ptw_rd && !ptw_resp_rdy_i) begin
				hold_vld_q <= 1'b1;
			end else if (hold_vld_q && ptw_resp_rdy_i) begin
				hold_vld_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ptw_rd) begin
			hold_q <= '{id: rd_ptw_i.id, pte: rd_q};
		end
	end

	// a new walk word must never land on a held one.
	a_hold_no_overrun: assert property (@(posedge clk) disable iff (!arst_n_i)
		ptw_rd |-> !hold_vld_q);

endmodule

// ==== hdl/l1d_fencei_ctrl.sv ====
`timescale 1ns/1ps

module l1d_fencei_ctrl (
	input  logic clk,
	input  logic arst_n_i,
	input  logic fencei_flush_vld_i,
	input  logic stb_empty_i,
	input  logic rd_busy_i,
	input  logic ld_q_empty_i,
	input  logic ptw_q_empty_i,
	output logic block_o,
	output logic fencei_flush_grant_o
);
	typedef enum logic [1:0] {
		FENCE_IDLE,
		FENCE_DRAIN,
		FENCE_GRANT
	} fence_state_e;

	fence_state_e state_q;
	fence_state_e state_d;
	logic         quiet;

	assign quiet = stb_empty_i & ~rd_busy_i & ld_q_empty_i & ptw_q_empty_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			FENCE_IDLE: begin
				if (fencei_flush_vld_i) begin
					state_d = FENCE_DRAIN;
				end
			end
			FENCE_DRAIN: begin
				if (quiet) begin
					state_d = FENCE_GRANT;
				end
			end
			default: state_d = FENCE_IDLE; // grant lasts one cycle.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= FENCE_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign block_o              = (state_q != FENCE_IDLE);
	assign fencei_flush_grant_o = (state_q == FENCE_GRANT);

endmodule

// ==== hdl/l1d_top.sv ====
`timescale 1ns/1ps
`include "l1d_defs.svh"

module l1d_top (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    ld_req_vld_i,
	input  l1d_req_pkg::ld_req_t    ld_req_i,
	output logic                    ld_req_rdy_o,
	input  logic                    st_req_vld_i,
	input  l1d_req_pkg::st_req_t    st_req_i,
	output logic                    st_req_rdy_o,
	input  logic                    ptw_walk_req_vld_i,
	input  l1d_req_pkg::ptw_req_t   ptw_walk_req_i,
	output logic                    ptw_walk_req_rdy_o,
	output logic                    ptw_walk_resp_vld_o,
	output l1d_resp_pkg::ptw_resp_t ptw_walk_resp_o,
	input  logic                    ptw_walk_resp_rdy_i,
	output logic                    rob_wb_vld_o,
	output l1d_resp_pkg::rob_wb_t   rob_wb_o,
	output logic                    ld_wb_vld_o,
	output l1d_resp_pkg::prf_wb_t   ld_wb_o,
	output l1d_resp_pkg::rob_wb_t   ld_rob_wb_o,
	input  logic                    fencei_flush_vld_i,
	output logic                    fencei_flush_grant_o
);
	logic                     block;
	logic                     ld_q_rdy, ld_q_vld, ld_q_empty, ld_gnt;
	logic                     ptw_q_rdy, ptw_q_vld, ptw_q_empty, ptw_gnt;
	logic                     stb_rdy, stb_drain_vld, stb_empty, st_gnt;
	logic                     bank_vld, rd_busy, ptw_hold;
	l1d_req_pkg::ld_req_t     ld_q_head, rd_ld;
	l1d_req_pkg::ptw_req_t    ptw_q_head, rd_ptw;
	l1d_req_pkg::bank_req_t   stb_drain_req, bank_req;
	l1d_req_pkg::bank_owner_e rd_owner;
	l1d_resp_pkg::prf_wb_t    bank_ld_wb;
	logic [`L1D_XLEN-1:0]     bank_rd_data, stb_byp_data;

	// ********************************************************************
	// fence.i gating, only on the request handshakes
	// ********************************************************************
	assign ld_req_rdy_o       = ld_q_rdy & ~block;
	assign st_req_rdy_o       = stb_rdy & ~block;
	assign ptw_walk_req_rdy_o = ptw_q_rdy & ~block;

	assign ld_wb_o.prd  = bank_ld_wb.prd;
	assign ld_wb_o.data = stb_byp_data; // bank word with pending stores merged.

	l1d_req_queue #(.payload_t(l1d_req_pkg::ld_req_t)) i_ld_queue (
		.clk(clk), .arst_n_i(arst_n_i),
		.push_vld_i(ld_req_vld_i & ~block), .push_data_i(ld_req_i), .pop_i(ld_gnt),
		.push_rdy_o(ld_q_rdy), .head_vld_o(ld_q_vld), .head_data_o(ld_q_head),
		.empty_o(ld_q_empty)
	);

	l1d_req_queue #(.payload_t(l1d_req_pkg::ptw_req_t)) i_ptw_queue (
		.clk(clk), .arst_n_i(arst_n_i),
		.push_vld_i(ptw_walk_req_vld_i & ~block), .push_data_i(ptw_walk_req_i),
		.pop_i(ptw_gnt), .push_rdy_o(ptw_q_rdy), .head_vld_o(ptw_q_vld),
		.head_data_o(ptw_q_head), .empty_o(ptw_q_empty)
	);

	l1d_store_buffer i_store_buffer (
		.clk(clk), .arst_n_i(arst_n_i),
		.st_vld_i(st_req_vld_i & ~block), .st_req_i(st_req_i), .drain_gnt_i(st_gnt),
		.byp_vld_i(ld_wb_vld_o), .byp_addr_i(rd_ld.addr), .byp_data_i(bank_rd_data),
		.st_rdy_o(stb_rdy), .rob_wb_vld_o(rob_wb_vld_o), .rob_wb_o(rob_wb_o),
		.drain_vld_o(stb_drain_vld), .drain_req_o(stb_drain_req),
		.byp_data_o(stb_byp_data), .empty_o(stb_empty)
	);

	l1d_bank_arbiter i_bank_arbiter (
		.clk(clk), .arst_n_i(arst_n_i),
		.ld_vld_i(ld_q_vld), .ld_req_i(ld_q_head),
		.ptw_vld_i(ptw_q_vld), .ptw_req_i(ptw_q_head),
		.st_vld_i(stb_drain_vld), .st_req_i(stb_drain_req),
		.stb_full_i(~stb_rdy), .ptw_hold_i(ptw_hold),
		.ld_gnt_o(ld_gnt), .ptw_gnt_o(ptw_gnt), .st_gnt_o(st_gnt),
		.bank_vld_o(bank_vld), .bank_req_o(bank_req), .rd_owner_o(rd_owner),
		.rd_ld_o(rd_ld), .rd_ptw_o(rd_ptw), .rd_busy_o(rd_busy)
	);

	l1d_data_bank i_data_bank (
		.clk(clk), .arst_n_i(arst_n_i),
		.req_vld_i(bank_vld), .req_i(bank_req), .rd_owner_i(rd_owner),
		.rd_ld_i(rd_ld), .rd_ptw_i(rd_ptw), .ptw_resp_rdy_i(ptw_walk_resp_rdy_i),
		.rd_data_o(bank_rd_data), .ld_rd_vld_o(ld_wb_vld_o), .ld_wb_o(bank_ld_wb),
		.ld_rob_o(ld_rob_wb_o), .ptw_resp_vld_o(ptw_walk_resp_vld_o),
		.ptw_resp_o(ptw_walk_resp_o), .ptw_hold_o(ptw_hold)
	);

	l1d_fencei_ctrl i_fencei_ctrl (
		.clk(clk), .arst_n_i(arst_n_i),
		.fencei_flush_vld_i(fencei_flush_vld_i), .stb_empty_i(stb_empty),
		.rd_busy_i(rd_busy), .ld_q_empty_i(ld_q_empty), .ptw_q_empty_i(ptw_q_empty),
		.block_o(block), .fencei_flush_grant_o(fencei_flush_grant_o)
	);

endmodule

// ==== testbench/l1d_top_tb.sv ====
`timescale 1ns/1ps
`include "l1d_defs.svh"

module l1d_top_tb;
	localparam int NAME_W = 8 * 24;

	logic                    clk;
	logic                    arst_n_i;
	logic                    ld_req_vld_i;
	l1d_req_pkg::ld_req_t    ld_req_i;
	logic                    ld_req_rdy_o;
	logic                    st_req_vld_i;
	l1d_req_pkg::st_req_t    st_req_i;
	logic                    st_req_rdy_o;
	logic                    ptw_walk_req_vld_i;
	l1d_req_pkg::ptw_req_t   ptw_walk_req_i;
	logic                    ptw_walk_req_rdy_o;
	logic                    ptw_walk_resp_vld_o;
	l1d_resp_pkg::ptw_resp_t ptw_walk_resp_o;
	logic                    ptw_walk_resp_rdy_i;
	logic                    rob_wb_vld_o;
	l1d_resp_pkg::rob_wb_t   rob_wb_o;
	logic                    ld_wb_vld_o;
	l1d_resp_pkg::prf_wb_t   ld_wb_o;
	l1d_resp_pkg::rob_wb_t   ld_rob_wb_o;
	logic                    fencei_flush_vld_i;
	logic                    fencei_flush_grant_o;

	logic [31:0]             op_q [$];
	logic [63:0]             a_q [$];
	logic [63:0]             b_q [$];
	logic [63:0]             addr_q [$];
	logic [63:0]             data_q [$];
	logic [63:0]             exp_q [$];
	logic [NAME_W-1:0]       name_q [$];
	logic [`L1D_XLEN-1:0]    model_mem [1 << `L1D_ADDR_W];
	l1d_resp_pkg::prf_wb_t   ld_exp_q [$];
	l1d_resp_pkg::rob_wb_t   ld_rob_exp_q [$];
	l1d_resp_pkg::ptw_resp_t ptw_exp_q [$];
	string                   ld_name_q [$];
	string                   ptw_name_q [$];
	int                      check_cnt = 0;
	int                      mismatch_cnt = 0;
	int                      error_cnt = 0;
	int                      cycle_cnt = 0;
	int                      cycle_limit = 0;
	logic [31:0]             gap_state;
	logic [31:0]             rdy_state;
	logic                    held_prev;
	l1d_resp_pkg::ptw_resp_t held_val;

	l1d_top i_l1d_top (
		.clk(clk), .arst_n_i(arst_n_i),
		.ld_req_vld_i(ld_req_vld_i), .ld_req_i(ld_req_i), .ld_req_rdy_o(ld_req_rdy_o),
		.st_req_vld_i(st_req_vld_i), .st_req_i(st_req_i), .st_req_rdy_o(st_req_rdy_o),
		.ptw_walk_req_vld_i(ptw_walk_req_vld_i), .ptw_walk_req_i(ptw_walk_req_i),
		.ptw_walk_req_rdy_o(ptw_walk_req_rdy_o), .ptw_walk_resp_vld_o(ptw_walk_resp_vld_o),
		.ptw_walk_resp_o(ptw_walk_resp_o), .ptw_walk_resp_rdy_i(ptw_walk_resp_rdy_i),
		.rob_wb_vld_o(rob_wb_vld_o), .rob_wb_o(rob_wb_o),
		.ld_wb_vld_o(ld_wb_vld_o), .ld_wb_o(ld_wb_o), .ld_rob_wb_o(ld_rob_wb_o),
		.fencei_flush_vld_i(fencei_flush_vld_i), .fencei_flush_grant_o(fencei_flush_grant_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	// ********************************************************************
	// reference model and compare tasks
	// ********************************************************************
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// a store writes the low 1, 2, 4 or 8 bytes of its word.
	function automatic logic [63:0] store_merge(input logic [63:0] old, input logic [1:0] op,
			input logic [63:0] data);
		int          nbytes;
		logic [63:0] res;
		case (op)
			`L1D_ST_OP_SB: nbytes = 1;
			`L1D_ST_OP_SH: nbytes = 2;
			`L1D_ST_OP_SW: nbytes = 4;
			default:       nbytes = 8;
		endcase
		res = old;
		for (int b = 0; b < nbytes; b++) begin
			res[b*8 +: 8] = data[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic check_rob(input string name, input l1d_resp_pkg::rob_wb_t exp_v,
			input l1d_resp_pkg::rob_wb_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			mismatch_cnt++;
			$display("Mismatch %s: expected %h actual %h", name, exp_v, act_v);
		end
	endtask

	task automatic check_ld(input string name, input l1d_resp_pkg::prf_wb_t exp_v,
			input l1d_resp_pkg::prf_wb_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			mismatch_cnt++;
			$display("Mismatch %s: expected %h actual %h", name, exp_v, act_v);
		end
	endtask

	task automatic check_ptw(input string name, input l1d_resp_pkg::ptw_resp_t exp_v,
			input l1d_resp_pkg::ptw_resp_t act_v);
		check_cnt++;
		if (act_v !== exp_v) begin
			mismatch_cnt++;
			$display("Mismatch %s: expected %h actual %h", name, exp_v, act_v);
		end
	endtask

	// ********************************************************************
	// request drivers, each entered and left 5 ns after a rising edge
	// ********************************************************************
	task automatic send_store(input string name, input logic [63:0] tag, input logic [63:0] op,
			input logic [63:0] addr, input logic [63:0] data);
		l1d_req_pkg::st_req_t  req;
		l1d_resp_pkg::rob_wb_t rob;
		req.rob_tag = tag[`L1D_ROB_TAG_W-1:0];
		req.op      = op[`L1D_ST_OP_W-1:0];
		req.addr    = addr[`L1D_ADDR_W-1:0];
		req.data    = data;
		rob.rob_tag = req.rob_tag;
		st_req_i     = req;
		st_req_vld_i = 1'b1;
		@(negedge clk);
		while (!st_req_rdy_o) @(negedge clk);
		if (!rob_wb_vld_o) begin
			error_cnt++;
			$display("ERROR: %s got no ROB writeback in its handshake cycle", name);
		end
		check_rob(name, rob, rob_wb_o);
		model_mem[req.addr] = store_merge(model_mem[req.addr], req.op, req.data);
		@(posedge clk);
		#5;
		st_req_vld_i = 1'b0;
	endtask

	task automatic send_load(input string name, input logic [63:0] tag, input logic [63:0] prd,
			input logic [63:0] addr, input logic [63:0] vec_word);
		l1d_req_pkg::ld_req_t  req;
		l1d_resp_pkg::prf_wb_t wb;
		l1d_resp_pkg::rob_wb_t rob;
		req.rob_tag = tag[`L1D_ROB_TAG_W-1:0];
		req.prd     = prd[`L1D_PREG_TAG_W-1:0];
		req.addr    = addr[`L1D_ADDR_W-1:0];
		wb.prd      = req.prd;
		rob.rob_tag = req.rob_tag;
		ld_req_i     = req;
		ld_req_vld_i = 1'b1;
		@(negedge clk);
		while (!ld_req_rdy_o) @(negedge clk);
		@(posedge clk);
		wb.data = model_mem[req.addr]; // stores taken up to the handshake are older.
		if (wb.data !== vec_word) begin
			error_cnt++;
			$display("ERROR: vector %s expects %h but the reference model gives %h",
				name, vec_word, wb.data);
		end
		ld_exp_q.push_back(wb);
		ld_rob_exp_q.push_back(rob);
		ld_name_q.push_back(name);
		#5;
		ld_req_vld_i = 1'b0;
	endtask

	task automatic send_walk(input string name, input logic [63:0] id, input logic [63:0] addr,
			input logic [63:0] word);
		l1d_req_pkg::ptw_req_t   req;
		l1d_resp_pkg::ptw_resp_t resp;
		req.id    = id[`L1D_PTW_ID_W-1:0];
		req.addr  = addr[`L1D_ADDR_W-1:0];
		resp.id   = req.id;
		resp.pte  = word;
		ptw_walk_req_i     = req;
		ptw_walk_req_vld_i = 1'b1;
		@(negedge clk);
		while (!ptw_walk_req_rdy_o) @(negedge clk);
		ptw_exp_q.push_back(resp);
		ptw_name_q.push_back(name);
		@(posedge clk);
		#5;
		ptw_walk_req_vld_i = 1'b0;
	endtask

	task automatic run_fence(input string name);
		logic granted;
		fencei_flush_vld_i = 1'b1;
		@(posedge clk);
		#5;
		fencei_flush_vld_i = 1'b0;
		granted = 1'b0;
		while (!granted) begin
			@(negedge clk);
			if (ld_req_rdy_o || st_req_rdy_o || ptw_walk_req_rdy_o) begin
				error_cnt++;
				$display("ERROR: %s saw a request ready high before the fence.i grant", name);
			end
			granted = fencei_flush_grant_o;
		end
		@(negedge clk);
		if (fencei_flush_grant_o) begin
			error_cnt++;
			$display("ERROR: %s fence.i grant lasted more than one cycle", name);
		end
		@(posedge clk);
		#5;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#5;
		end
	endtask

	// ********************************************************************
	// result monitor, sampled on the falling edge
	// ********************************************************************
	always @(negedge clk) begin : watch_results
		string nm;
		if (arst_n_i) begin
			if (ld_wb_vld_o) begin
				if (ld_exp_q.size() == 0) begin
					error_cnt++;
					$display("ERROR: load writeback with no load outstanding");
				end else begin
					nm = ld_name_q.pop_front();
					check_ld(nm, ld_exp_q.pop_front(), ld_wb_o);
					check_rob(nm, ld_rob_exp_q.pop_front(), ld_rob_wb_o);
				end
			end
			if (held_prev && (!ptw_walk_resp_vld_o || ptw_walk_resp_o !== held_val)) begin
				error_cnt++;
				$display("ERROR: held walk response changed before it was taken");
			end
			held_prev = ptw_walk_resp_vld_o & ~ptw_walk_resp_rdy_i;
			held_val  = ptw_walk_resp_o;
			if (ptw_walk_resp_vld_o && ptw_walk_resp_rdy_i) begin
				if (ptw_exp_q.size() == 0) begin
					error_cnt++;
					$display("ERROR: walk response with no walk outstanding");
				end else begin
					nm = ptw_name_q.pop_front();
					check_ptw(nm, ptw_exp_q.pop_front(), ptw_walk_resp_o);
				end
			end
		end
	end

	// random stalls on the walk response ready.
	initial begin
		ptw_walk_resp_rdy_i = 1'b1;
		rdy_state = 32'd53;
		forever begin
			@(posedge clk);
			#5;
			rdy_state = xorshift32(rdy_state);
			ptw_walk_resp_rdy_i = rdy_state[2] | rdy_state[7];
		end
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("ERROR: run timed out after %0d cycles", cycle_cnt);
		$display("checks %0d, mismatches %0d, other errors %0d", check_cnt, mismatch_cnt,
			error_cnt);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ********************************************************************
	// vector playback
	// ********************************************************************
	initial begin
		int                   fd;
		int                   n;
		logic [8*160-1:0]     line;
		logic [31:0]          op_r;
		logic [63:0]          a;
		logic [63:0]          b;
		logic [63:0]          addr;
		logic [63:0]          d;
		logic [63:0]          e;
		logic [NAME_W-1:0]    name_r;
		logic [`L1D_XLEN-1:0] mval;
		string                name;
		string                lname;
		arst_n_i           = 1'b0;
		ld_req_vld_i       = 1'b0;
		ld_req_i           = '0;
		st_req_vld_i       = 1'b0;
		st_req_i           = '0;
		ptw_walk_req_vld_i = 1'b0;
		ptw_walk_req_i     = '0;
		fencei_flush_vld_i = 1'b0;
		held_prev          = 1'b0;
		held_val           = '0;
		gap_state          = 32'd53;
		for (int i = 0; i < (1 << `L1D_ADDR_W); i++) begin
			model_mem[i] = '0;
		end
		fd = $fopen("testbench/l1d_vectors.txt", "r");
		if (fd == 0) begin
			error_cnt++;
			$display("ERROR: cannot open the vector file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s %h %h %h %h %h %s", op_r, a, b, addr, d, e, name_r);
				if (n == 7) begin
					op_q.push_back(op_r);
					a_q.push_back(a);
					b_q.push_back(b);
					addr_q.push_back(addr);
					data_q.push_back(d);
					exp_q.push_back(e);
					name_q.push_back(name_r);
				end else if (n > 0 && op_r != "#") begin
					error_cnt++;
					$display("ERROR: malformed vector line skipped");
				end
			end
			$fclose(fd);
		end
		cycle_limit = 16 + 40 * op_q.size(); // reset plus 40 cycles per line.

		repeat (16) @(posedge clk);
		#5;
		arst_n_i = 1'b1;
		@(negedge clk);
		if (rob_wb_vld_o || ld_wb_vld_o || ptw_walk_resp_vld_o || fencei_flush_grant_o) begin
			error_cnt++;
			$display("ERROR: a valid output or the grant is high after reset");
		end
		if (!ld_req_rdy_o || !st_req_rdy_o || !ptw_walk_req_rdy_o) begin
			error_cnt++;
			$display("ERROR: a request ready is low after reset");
		end
		@(posedge clk);
		#5;

		for (int i = 0; i < op_q.size(); i++) begin
			name = $sformatf("%0s", name_q[i]);
			mval = model_mem[addr_q[i][`L1D_ADDR_W-1:0]];
			if (op_q[i] == "pw" && mval !== exp_q[i]) begin
				error_cnt++;
				$display("ERROR: vector %s expects %h but the reference model gives %h",
					name, exp_q[i], mval);
			end
			if (op_q[i] == "st" && i + 1 < op_q.size() && op_q[i + 1] == "ld") begin
				// the load goes out with the store, so it meets that store still buffered.
				lname = $sformatf("%0s", name_q[i + 1]);
				fork
					send_store(name, a_q[i], b_q[i], addr_q[i], data_q[i]);
					send_load(lname, a_q[i + 1], b_q[i + 1], addr_q[i + 1], exp_q[i + 1]);
				join
				i++;
			end else if (op_q[i] == "st") begin
				send_store(name, a_q[i], b_q[i], addr_q[i], data_q[i]);
			end else if (op_q[i] == "ld") begin
				send_load(name, a_q[i], b_q[i], addr_q[i], exp_q[i]);
			end else if (op_q[i] == "pw") begin
				send_walk(name, a_q[i], addr_q[i], mval);
			end else if (op_q[i] == "fe") begin
				run_fence(name);
			end else if (op_q[i] == "id") begin
				idle_cycles(int'(a_q[i]));
			end else begin
				error_cnt++;
				$display("ERROR: unknown operation in vector %s", name);
			end
			gap_state = xorshift32(gap_state);
			idle_cycles(int'(gap_state[0] & gap_state[3])); // random gap of one cycle.
		end

		while (ld_exp_q.size() != 0 || ptw_exp_q.size() != 0) @(negedge clk);
		$display("checks %0d, mismatches %0d, other errors %0d", check_cnt, mismatch_cnt,
			error_cnt);
		if (mismatch_cnt == 0 && error_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== l1d_top.f ====
+incdir+hdl
hdl/l1d_req_pkg.sv
hdl/l1d_resp_pkg.sv
hdl/l1d_req_queue.sv
hdl/l1d_store_buffer.sv
hdl/l1d_bank_arbiter.sv
hdl/l1d_data_bank.sv
hdl/l1d_fencei_ctrl.sv
hdl/l1d_top.sv
testbench/l1d_top_tb.sv

// ==== testbench/l1d_vectors.txt ====
# op a  b  addr data             expect           name
# st a=rob tag b=opcode, ld a=rob tag b=prd, pw a=walk id, id a=idle cycles, fe no operands
st 1 3  0 1111111111111111 1                init_w0
st 2 3  1 2222222222222222 2                init_w1
st 3 3  2 3333333333333333 3                init_w2
st 4 3  3 4444444444444444 4                init_w3
st 5 3  4 5555555555555555 5                init_w4
st 6 3  5 6666666666666666 6                init_w5
id a 0  0 0                0                drain_init
ld 7 01 0 0                1111111111111111 ld_drained_w0
ld 8 02 1 0                2222222222222222 ld_drained_w1
ld 9 03 5 0                6666666666666666 ld_drained_w5
st a 1  2 000000000000dddd a                byp_sh_w2
st b 0  2 00000000000000ee b                byp_sb_w2
ld c 04 2 0                333333333333ddee byp_ld_w2
st d 2  3 0000000087654321 d                byp_sw_w3
st e 0  3 ffffffffffffff99 e                byp_sb_w3
ld f 05 3 0                4444444487654399 byp_ld_w3
id 1 0  0 0                0                gap_w4
st 0 3  4 0123456789abcdef 0                byp_sd_w4
ld 1 06 4 0                0123456789abcdef byp_ld_w4
fe 0 0  0 0                0                fence_first
pw 0 0  2 0                333333333333ddee walk_w2
pw 1 0  3 0                4444444487654399 walk_w3
pw 0 0  4 0                0123456789abcdef walk_w4
pw 1 0  0 0                1111111111111111 walk_w0
pw 0 0  5 0                6666666666666666 walk_w5
id 6 0  0 0                0                walk_settle
st 2 2  1 00000000aabbccdd 2                fence_sw_w1
st 3 1  1 0000000000001234 3                fence_sh_w1
fe 0 0  0 0                0                fence_after_st
pw 1 0  1 0                22222222aabb1234 walk_after_fence
ld 4 07 1 0                22222222aabb1234 ld_after_fence
st 5 3  0 fedcba9876543210 5                sd_w0_late
id 4 0  0 0                0                drain_late
ld 6 08 0 0                fedcba9876543210 ld_late_w0
ld 7 09 2 0                333333333333ddee ld_late_w2
ld 8 0a 3 0                4444444487654399 ld_late_w3
id 8 0  0 0                0                final_idle
